// ==== Bender.yml ====
package:
  name: taint_mul

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mul_pkg.sv
      - mul_sequencer.sv
      - mul_datapath.sv
      - mul_result.sv
      - taint_mul_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_taint_mul.sv

// ==== mul_cfg.svh ====
//====================================================================
// Operand width and testbench run length for the taint-tracking
// shift-add multiplier
//====================================================================

`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// Operand width in bits
// The sum register is 2*MUL_WIDTH+1 wide to keep the add carry
`define MUL_WIDTH 4

// Random multiplications per testbench run
`define MUL_TB_ITERS 200

`endif

// ==== mul_datapath.sv ====
//====================================================================
// Multiplier datapath: multiplicand, multiplier and running-sum
// registers with shadow taint and carry-taint tracking
//====================================================================

`timescale 1ns/1ns
`default_nettype none

`include "mul_cfg.svh"

module mul_datapath (
    input  wire                     clk,
    input  wire                     rst,
    input  wire mul_pkg::op_word_t  multiplier,
    input  wire mul_pkg::op_word_t  multiplier_t,
    input  wire mul_pkg::op_word_t  multiplicand,
    input  wire mul_pkg::op_word_t  multiplicand_t,
    input  wire                     mdld,
    input  wire                     mdld_t,
    input  wire                     mrld,
    input  wire                     mrld_t,
    input  wire                     rsclear,
    input  wire                     rsclear_t,
    input  wire                     rsload,
    input  wire                     rsload_t,
    input  wire                     rsshr,
    input  wire                     rsshr_t,
    output mul_pkg::op_word_t       multiplier_reg,
    output mul_pkg::acc_word_t      run_sum,
    output mul_pkg::acc_word_t      run_sum_t
);
    import mul_pkg::*;

    localparam int ACC_W = 2 * `MUL_WIDTH + 1;

    acc_word_t multiplicand_reg;
    acc_word_t multiplicand_reg_t;
    acc_word_t carry;
    acc_word_t carry_t;
    acc_word_t md_ctrl_t;
    acc_word_t sum_ctrl_t;

    // Strobe taint spreads over the whole register it acts on
    assign md_ctrl_t  = {ACC_W{mdld_t}};
    assign sum_ctrl_t = {ACC_W{rsclear_t | rsload_t | rsshr_t}};

    //==================================================================
    // Carry chain and carry taint of multiplicand + running sum
    //==================================================================
    always_comb begin
        carry   = '0;
        carry_t = '0;
        for (int i = 0; i < ACC_W - 1; i++) begin
            if ((multiplicand_reg[i] & run_sum[i]) |
                (multiplicand_reg[i] & carry[i]) |
                (run_sum[i] & carry[i])) begin
                // Real carry out of bit i, tainted by either operand bit
                carry[i+1]   = 1'b1;
                carry_t[i+1] = multiplicand_reg_t[i] | run_sum_t[i];
            end
        end
    end

    //==================================================================
    // Operand registers
    //==================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            multiplicand_reg   <= '0;
            multiplicand_reg_t <= '0;
        end else if (mdld) begin
            // Multiplicand sits in the upper half
            multiplicand_reg   <= {1'b0, multiplicand, {`MUL_WIDTH{1'b0}}};
            multiplicand_reg_t <= {1'b0, multiplicand_t, {`MUL_WIDTH{1'b0}}} | md_ctrl_t;
        end else begin
            multiplicand_reg_t <= multiplicand_reg_t | md_ctrl_t;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            multiplier_reg <= '0;
        end else if (mrld) begin
            multiplier_reg <= multiplier;
        end
    end

    //==================================================================
    // Running sum
    //==================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            run_sum   <= '0;
            run_sum_t <= '0;
        end else if (rsclear) begin
            run_sum   <= '0;
            run_sum_t <= sum_ctrl_t;
        end else if (rsload) begin
            run_sum   <= run_sum + multiplicand_reg;
            run_sum_t <= run_sum_t | multiplicand_reg_t | carry_t | sum_ctrl_t;
        end else if (rsshr) begin
            // Unsigned sum, so the top bit fills with zero
            run_sum   <= run_sum >>> 1;
            run_sum_t <= (run_sum_t >>> 1) | sum_ctrl_t;
        end else begin
            run_sum_t <= run_sum_t | sum_ctrl_t;
        end
    end

endmodule

`default_nettype wire

// ==== mul_pkg.sv ====
//====================================================================
// Word types and sequencer state for the taint-tracking multiplier
//====================================================================

`default_nettype none

`include "mul_cfg.svh"

package mul_pkg;

    // Operands, operand taint and the multiplier register
    typedef logic [`MUL_WIDTH-1:0] op_word_t;

    // Multiplicand and running sum, one spare bit for the add carry
    typedef logic [2*`MUL_WIDTH:0] acc_word_t;

    // Finished product and its taint
    typedef logic [2*`MUL_WIDTH-1:0] prod_word_t;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        ADD,
        SHIFT,
        FINISH
    } seq_state_t;

endpackage

`default_nettype wire

// ==== mul_result.sv ====
//====================================================================
// Product capture register with taint and summary taint flag
//====================================================================

`timescale 1ns/1ns
`default_nettype none

`include "mul_cfg.svh"

module mul_result (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     finish,
    input  wire mul_pkg::acc_word_t run_sum,
    input  wire mul_pkg::acc_word_t run_sum_t,
    output mul_pkg::prod_word_t     product,
    output mul_pkg::prod_word_t     product_t,
    output logic                    product_tainted,
    output logic                    done
);
    localparam int PROD_W = 2 * `MUL_WIDTH;

    // Carry bit of the sum is dropped, product holds until next finish
    always_ff @(posedge clk) begin
        if (rst) begin
            product   <= '0;
            product_t <= '0;
            done      <= 1'b0;
        end else begin
            done <= finish;
            if (finish) begin
                product   <= run_sum[PROD_W-1:0];
                product_t <= run_sum_t[PROD_W-1:0];
            end
        end
    end

    // Any tainted product bit flags the whole result
    assign product_tainted = |product_t;

endmodule

`default_nettype wire

// ==== mul_sequencer.sv ====
//====================================================================
// Multiplier control FSM: load, add/skip and shift strobes, each
// with a shadow taint taken from the start strobe
//====================================================================

`timescale 1ns/1ns
`default_nettype none

`include "mul_cfg.svh"

module mul_sequencer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    start,
    input  wire                    start_t,
    input  wire mul_pkg::op_word_t multiplier_reg,
    output logic                   mdld,
    output logic                   mdld_t,
    output logic                   mrld,
    output logic                   mrld_t,
    output logic                   rsclear,
    output logic                   rsclear_t,
    output logic                   rsload,
    output logic                   rsload_t,
    output logic                   rsshr,
    output logic                   rsshr_t,
    output logic                   finish,
    output logic                   busy
);
    import mul_pkg::*;

    localparam int IDX_W = (`MUL_WIDTH > 1) ? $clog2(`MUL_WIDTH) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`MUL_WIDTH - 1);

    seq_state_t       state;
    logic [IDX_W-1:0] bit_idx;
    logic             ctrl_taint;
    logic             strobe_t;

    //==================================================================
    // State register
    //==================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            bit_idx    <= '0;
            ctrl_taint <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // start is only looked at here
                    if (start) begin
                        state      <= LOAD;
                        ctrl_taint <= start_t;
                    end
                end
                LOAD: begin
                    state   <= ADD;
                    bit_idx <= '0;
                end
                ADD: begin
                    state <= SHIFT;
                end
                SHIFT: begin
                    if (bit_idx == LAST_IDX) begin
                        state <= FINISH;
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                        state   <= ADD;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    //==================================================================
    // Strobe decode
    //==================================================================
    assign busy     = (state != IDLE);
    assign strobe_t = busy & ctrl_taint;

    // Operand loads and sum clear share the LOAD cycle
    assign mdld    = (state == LOAD);
    assign mrld    = (state == LOAD);
    assign rsclear = (state == LOAD);

    // Add only when the current multiplier bit is set
    assign rsload = (state == ADD) & multiplier_reg[bit_idx];
    assign rsshr  = (state == SHIFT);
    assign finish = (state == FINISH);

    // A tainted start taints every strobe of that multiplication
    assign mdld_t    = strobe_t;
    assign mrld_t    = strobe_t;
    assign rsclear_t = strobe_t;
    assign rsload_t  = strobe_t;
    assign rsshr_t   = strobe_t;

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
mul_pkg.sv
mul_sequencer.sv
mul_datapath.sv
mul_result.sv
taint_mul_top.sv
tb_taint_mul.sv

// ==== taint_mul_top.sv ====
//====================================================================
// Taint-tracking multiplier top: sequencer, datapath, result stage
//====================================================================

`timescale 1ns/1ns
`default_nettype none

module taint_mul_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     start,
    input  wire                     start_t,
    input  wire mul_pkg::op_word_t  multiplier,
    input  wire mul_pkg::op_word_t  multiplier_t,
    input  wire mul_pkg::op_word_t  multiplicand,
    input  wire mul_pkg::op_word_t  multiplicand_t,
    output mul_pkg::prod_word_t     product,
    output mul_pkg::prod_word_t     product_t,
    output logic                    product_tainted,
    output logic                    done,
    output logic                    busy
);
    import mul_pkg::*;

    // Strobes and their taint twins
    logic mdld;
    logic mdld_t;
    logic mrld;
    logic mrld_t;
    logic rsclear;
    logic rsclear_t;
    logic rsload;
    logic rsload_t;
    logic rsshr;
    logic rsshr_t;
    logic finish;

    op_word_t  multiplier_reg;
    acc_word_t run_sum;
    acc_word_t run_sum_t;

    mul_sequencer mul_sequencer_i (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .start_t        (start_t),
        .multiplier_reg (multiplier_reg),
        .mdld           (mdld),
        .mdld_t         (mdld_t),
        .mrld           (mrld),
        .mrld_t         (mrld_t),
        .rsclear        (rsclear),
        .rsclear_t      (rsclear_t),
        .rsload         (rsload),
        .rsload_t       (rsload_t),
        .rsshr          (rsshr),
        .rsshr_t        (rsshr_t),
        .finish         (finish),
        .busy           (busy)
    );

    mul_datapath mul_datapath_i (
        .clk            (clk),
        .rst            (rst),
        .multiplier     (multiplier),
        .multiplier_t   (multiplier_t),
        .multiplicand   (multiplicand),
        .multiplicand_t (multiplicand_t),
        .mdld           (mdld),
        .mdld_t         (mdld_t),
        .mrld           (mrld),
        .mrld_t         (mrld_t),
        .rsclear        (rsclear),
        .rsclear_t      (rsclear_t),
        .rsload         (rsload),
        .rsload_t       (rsload_t),
        .rsshr          (rsshr),
        .rsshr_t        (rsshr_t),
        .multiplier_reg (multiplier_reg),
        .run_sum        (run_sum),
        .run_sum_t      (run_sum_t)
    );

    mul_result mul_result_i (
        .clk             (clk),
        .rst             (rst),
        .finish          (finish),
        .run_sum         (run_sum),
        .run_sum_t       (run_sum_t),
        .product         (product),
        .product_t       (product_t),
        .product_tainted (product_tainted),
        .done            (done)
    );

endmodule

`default_nettype wire

// ==== tb_taint_mul.sv ====
//====================================================================
// Random-stimulus testbench for the taint-tracking multiplier with a
// bit-level model of product, taint and done timing
//====================================================================

`timescale 1ns/1ns
`default_nettype none

`include "mul_cfg.svh"

module tb_taint_mul;
    import mul_pkg::*;

    localparam int W      = `MUL_WIDTH;
    localparam int ACC_W  = 2 * `MUL_WIDTH + 1;
    localparam int PROD_W = 2 * `MUL_WIDTH;
    localparam int DONE_LATENCY = 2 * `MUL_WIDTH + 3;

    logic       clk;
    logic       rst;
    logic       start;
    logic       start_t;
    op_word_t   multiplier;
    op_word_t   multiplier_t;
    op_word_t   multiplicand;
    op_word_t   multiplicand_t;
    prod_word_t product;
    prod_word_t product_t;
    logic       product_tainted;
    logic       done;
    logic       busy;

    // Result of the previous multiplication, expected to hold until done
    prod_word_t prev_product;
    prod_word_t prev_product_t;

    taint_mul_top taint_mul_top_i (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .start_t         (start_t),
        .multiplier      (multiplier),
        .multiplier_t    (multiplier_t),
        .multiplicand    (multiplicand),
        .multiplicand_t  (multiplicand_t),
        .product         (product),
        .product_t       (product_t),
        .product_tainted (product_tainted),
        .done            (done),
        .busy            (busy)
    );

    always #20 clk = ~clk;

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    //==================================================================
    // Reference model: load, then add/skip and shift per multiplier bit
    //==================================================================
    function automatic void model_product(input op_word_t mr, input op_word_t md_in,
                                          input op_word_t md_in_t, input logic st,
                                          output prod_word_t p, output prod_word_t pt);
        acc_word_t ctl;
        acc_word_t md;
        acc_word_t md_t;
        acc_word_t sum;
        acc_word_t sum_t;
        acc_word_t total;
        acc_word_t carry_in;
        acc_word_t carry_t;
        ctl   = {ACC_W{st}};
        md    = {1'b0, md_in, {W{1'b0}}};
        md_t  = {1'b0, md_in_t, {W{1'b0}}} | ctl;
        sum   = '0;
        sum_t = ctl;
        for (int i = 0; i < W; i++) begin
            if (mr[i]) begin
                total    = sum + md;
                // Carry into each bit, recovered from the sum bits
                carry_in = total ^ sum ^ md;
                carry_t  = carry_in & ((md_t | sum_t) << 1);
                sum_t    = sum_t | md_t | carry_t | ctl;
                sum      = total;
            end else begin
                sum_t = sum_t | ctl;
            end
            sum   = sum >> 1;
            sum_t = (sum_t >> 1) | ctl;
        end
        p  = sum[PROD_W-1:0];
        pt = sum_t[PROD_W-1:0];
    endfunction

    //==================================================================
    // One multiplication, optional ignored start while busy
    //==================================================================
    task automatic run_multiply(input int iter);
        int         mode;
        int         cycles;
        logic       got_done;
        logic       second_start;
        op_word_t   a;
        op_word_t   b;
        op_word_t   bt;
        logic       st;
        prod_word_t exp_p;
        prod_word_t exp_t;
        prod_word_t exp_mul;
        mode         = iter % 3;
        second_start = (iter % 4 == 3);
        a            = op_word_t'($urandom);
        b            = op_word_t'($urandom);
        // Mode 0 untainted, mode 1 operand taint, mode 2 tainted start
        bt = (mode == 0) ? '0 : op_word_t'($urandom);
        st = (mode == 2);
        model_product(a, b, bt, st, exp_p, exp_t);
        exp_mul = a * b;

        @(posedge clk);
        start          <= 1'b1;
        start_t        <= st;
        multiplier     <= a;
        multiplier_t   <= (mode == 0) ? '0 : op_word_t'($urandom);
        multiplicand   <= b;
        multiplicand_t <= bt;

        cycles   = 0;
        got_done = 1'b0;
        while (!got_done && cycles < 4 * W) begin
            @(posedge clk);
            cycles++;
            if (cycles == 1) begin
                start   <= 1'b0;
                start_t <= 1'b0;
            end
            if (second_start && cycles == W + 1) begin
                start        <= 1'b1;
                start_t      <= 1'b1;
                multiplier   <= op_word_t'($urandom);
                multiplicand <= op_word_t'($urandom);
            end
            if (second_start && cycles == W + 2) begin
                start   <= 1'b0;
                start_t <= 1'b0;
            end
            @(negedge clk);
            if (cycles == 2) begin
                check_equal("busy after start", busy, 1'b1);
            end
            got_done = done;
            if (!got_done) begin
                check_equal("product held before done", product, prev_product);
                check_equal("product_t held before done", product_t, prev_product_t);
            end
        end
        if (!got_done) begin
            $display("Timeout: done did not rise within %0d cycles of start", 4 * W);
            $display("TEST FAILED");
            $fatal(1);
        end

        check_equal("done latency", cycles, DONE_LATENCY);
        check_equal("product value", product, exp_p);
        check_equal("product vs multiply", product, exp_mul);
        check_equal("product taint", product_t, exp_t);
        check_equal("product_tainted", product_tainted, |exp_t);
        if (st) begin
            check_equal("taint under tainted start", product_t, {PROD_W{1'b1}});
        end
        if (mode == 0) begin
            check_equal("untainted product_t", product_t, '0);
        end
        prev_product   = exp_p;
        prev_product_t = exp_t;

        // done is a single pulse
        @(negedge clk);
        check_equal("done after pulse", done, 1'b0);
        check_equal("busy after done", busy, 1'b0);
    endtask

    //==================================================================
    // Main sequence
    //==================================================================
    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        start          = 1'b0;
        start_t        = 1'b0;
        multiplier     = '0;
        multiplier_t   = '0;
        multiplicand   = '0;
        multiplicand_t = '0;
        prev_product   = '0;
        prev_product_t = '0;
        void'($urandom(32'ha1f0));

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_equal("done after reset", done, 1'b0);
        check_equal("busy after reset", busy, 1'b0);
        check_equal("product after reset", product, '0);
        check_equal("product_t after reset", product_t, '0);
        check_equal("product_tainted after reset", product_tainted, 1'b0);

        for (int iter = 0; iter < `MUL_TB_ITERS; iter++) begin
            run_multiply(iter);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
